// ==== fb_addr_decode.sv ====
/*
 * Address decode stage
 * Registers one master command with its one-hot target select and
 * holds both until the router takes them; response passes straight back
 */

`timescale 1ns/1ps

module fb_addr_decode import fb_pkg::*; (
   input  logic             clk,
   input  logic             rst,
   input  logic             cmd_valid,
   output logic             cmd_ready,
   input  logic [fb_aw-1:0] cmd_addr,
   input  logic [fb_mw-1:0] cmd_we_msk,
   input  logic [fb_dw-1:0] cmd_din,
   output logic             rsp_valid,
   input  logic             rsp_ready,
   output logic [fb_dw-1:0] rsp_data,
   fb_cmd_if.source         down
);

   logic               hold_vld;
   fb_cmd_t            hold_cmd;
   logic [fb_nbus-1:0] hold_sel;
   logic [fb_nbus-1:0] sel_d;
   logic               accept;

   // Take a new command when empty or when the held one leaves this cycle
   assign cmd_ready = ~hold_vld | down.cmd_ready;
   assign accept    = cmd_valid & cmd_ready;

   // One select bit per target
   always_comb begin
      sel_d           = '0;
      sel_d[tgt_sram] = ~cmd_addr[fb_sel_bit];
      sel_d[tgt_regs] = cmd_addr[fb_sel_bit];
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         hold_vld <= 1'b0;
      end else if (cmd_ready) begin
         hold_vld <= cmd_valid;
      end
   end

   // Payload only loads on an accepted command
   always_ff @(posedge clk) begin
      if (accept) begin
         hold_cmd.addr   <= cmd_addr;
         hold_cmd.we_msk <= cmd_we_msk;
         hold_cmd.din    <= cmd_din;
         hold_sel        <= sel_d;
      end
   end

   assign down.cmd_valid = hold_vld;
   assign down.cmd       = hold_cmd;
   assign down.sel       = hold_sel;

   // Response channel back out to the top ports
   assign rsp_valid      = down.rsp_valid;
   assign rsp_data       = down.rsp_data;
   assign down.rsp_ready = rsp_ready;

   // Held select stays one-hot for as long as the command waits
   a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
      hold_vld |-> $onehot(hold_sel));

endmodule

// ==== fb_if.sv ====
/*
 * Frontend bus interfaces
 * fb_cmd_if carries the decoded command channel and its response,
 * fb_tgt_if carries one target bus between the router and a target
 */

`timescale 1ns/1ps

interface fb_cmd_if import fb_pkg::*; ();
   logic               cmd_valid;
   logic               cmd_ready;
   fb_cmd_t            cmd;
   // One-hot target select, decoded from the address
   logic [fb_nbus-1:0] sel;
   logic               rsp_valid;
   logic               rsp_ready;
   logic [fb_dw-1:0]   rsp_data;

   // Decode stage side
   modport source (output cmd_valid, cmd, sel, rsp_ready,
                   input  cmd_ready, rsp_valid, rsp_data);
   // Router side
   modport sink   (input  cmd_valid, cmd, sel, rsp_ready,
                   output cmd_ready, rsp_valid, rsp_data);
endinterface

interface fb_tgt_if import fb_pkg::*; ();
   logic             cmd_valid;
   logic             cmd_ready;
   logic [fb_aw-1:0] addr;
   logic [fb_mw-1:0] we_msk;
   logic [fb_dw-1:0] din;
   // Response channel
   logic             valid;
   logic             ready;
   logic [fb_dw-1:0] dout;

   modport router (output cmd_valid, addr, we_msk, din, ready,
                   input  cmd_ready, valid, dout);
   modport target (input  cmd_valid, addr, we_msk, din, ready,
                   output cmd_ready, valid, dout);
endinterface

// ==== fb_pkg.sv ====
/*
 * Frontend bus package
 * Bus widths, target count, address map and the command payload type
 * shared by the decode stage, the router and the targets
 */

package fb_pkg;

   // Bus widths
   localparam int fb_aw = 16;
   localparam int fb_dw = 32;
   localparam int fb_mw = fb_dw / 8;

   // Target count and target indices
   localparam int fb_nbus  = 2;
   localparam int tgt_sram = 0;
   localparam int tgt_regs = 1;

   // One address bit picks the target
   // 0 selects the SRAM, 1 selects the register bank
   localparam int fb_sel_bit = 12;

   // Command payload as held by the decode stage
   typedef struct packed {
      logic [fb_aw-1:0] addr;
      logic [fb_mw-1:0] we_msk;
      logic [fb_dw-1:0] din;
   } fb_cmd_t;

   // Byte-masked merge of write data into a stored word
   // A zero mask leaves the word untouched, so reads share this path
   function automatic logic [fb_dw-1:0] fb_merge(input logic [fb_dw-1:0] old_w,
                                                 input logic [fb_dw-1:0] new_w,
                                                 input logic [fb_mw-1:0] msk);
      logic [fb_dw-1:0] res;
      res = old_w;
      for (int b = 0; b < fb_mw; b++) begin
         if (msk[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

endpackage

// ==== fb_reg_target.sv ====
/*
 * Register bank target
 * Four word registers with masked writes; a countdown holds the
 * response back reg_latency cycles to model a slow peripheral
 */

`timescale 1ns/1ps

module fb_reg_target import fb_pkg::*; #(
   parameter int reg_latency = 3
) (
   input  logic      clk,
   input  logic      rst,
   fb_tgt_if.target  bus
);

   localparam int cw = $clog2(reg_latency + 1);

   logic [fb_dw-1:0] regs [4];
   logic [1:0]       idx;
   logic [fb_dw-1:0] merged;
   logic [fb_dw-1:0] dout_q;
   logic [cw-1:0]    cnt;
   logic             rsp_vld;
   logic             hs_cmd;

   assign idx    = bus.addr[3:2];
   assign merged = fb_merge(regs[idx], bus.din, bus.we_msk);
   assign hs_cmd = bus.cmd_valid & bus.cmd_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int r = 0; r < 4; r++) begin
            regs[r] <= '0;
         end
      end else if (hs_cmd) begin
         regs[idx] <= merged;
      end
   end

   // Response word captured at the command, released later
   always_ff @(posedge clk) begin
      if (hs_cmd) begin
         dout_q <= merged;
      end
   end

   // Countdown then response; latency 1 skips the count
   always_ff @(posedge clk) begin
      if (rst) begin
         cnt     <= '0;
         rsp_vld <= 1'b0;
      end else begin
         if (hs_cmd) begin
            if (reg_latency == 1) begin
               rsp_vld <= 1'b1;
            end else begin
               cnt <= cw'(reg_latency - 1);
            end
         end
         if (cnt != '0) begin
            cnt <= cnt - 1'b1;
            if (cnt == cw'(1)) begin
               rsp_vld <= 1'b1;
            end
         end
         if (rsp_vld & bus.ready) begin
            rsp_vld <= 1'b0;
         end
      end
   end

   assign bus.cmd_ready = (cnt == '0) & ~rsp_vld;
   assign bus.valid     = rsp_vld;
   assign bus.dout      = dout_q;

   // Bank stays closed for at least reg_latency cycles after a command
   a_busy: assert property (@(posedge clk) disable iff (rst)
      hs_cmd |=> (!bus.cmd_ready) [*reg_latency]);

endmodule

// ==== fb_sram_target.sv ====
/*
 * SRAM target
 * Word memory with byte write mask; returns the word after the
 * write one cycle after the command transfer
 */

`timescale 1ns/1ps

module fb_sram_target import fb_pkg::*; #(
   parameter int sram_words = 256
) (
   input  logic      clk,
   input  logic      rst,
   fb_tgt_if.target  bus
);

   localparam int iw = $clog2(sram_words);

   logic [fb_dw-1:0] mem [sram_words];
   logic [iw-1:0]    idx;
   logic [fb_dw-1:0] merged;
   logic [fb_dw-1:0] dout_q;
   logic             valid_q;
   logic             hs_cmd;

   // Word addressing, byte offset bits dropped
   assign idx    = bus.addr[iw+1:2];
   assign merged = fb_merge(mem[idx], bus.din, bus.we_msk);
   assign hs_cmd = bus.cmd_valid & bus.cmd_ready;

   // Write back the merged word, reads rewrite the same value
   always_ff @(posedge clk) begin
      if (hs_cmd) begin
         mem[idx] <= merged;
         dout_q   <= merged;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= 1'b0;
      end else if (hs_cmd) begin
         valid_q <= 1'b1;
      end else if (bus.ready) begin
         valid_q <= 1'b0;
      end
   end

   // Held response blocks new commands
   assign bus.cmd_ready = ~valid_q;
   assign bus.valid     = valid_q;
   assign bus.dout      = dout_q;

   // Response stays up with the same word until taken
   a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
      (valid_q & ~bus.ready) |=> (valid_q && $stable(dout_q)));

endmodule

// ==== fb_subsystem_top.sv ====
/*
 * Frontend bus subsystem top
 * Address decode stage, router, SRAM target and register bank,
 * with the master command and response channels as plain ports
 */

`timescale 1ns/1ps

module fb_subsystem_top import fb_pkg::*; #(
   parameter int sram_words  = 256,
   parameter int reg_latency = 3
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             cmd_valid,
   output logic             cmd_ready,
   input  logic [fb_aw-1:0] cmd_addr,
   input  logic [fb_mw-1:0] cmd_we_msk,
   input  logic [fb_dw-1:0] cmd_din,
   output logic             rsp_valid,
   input  logic             rsp_ready,
   output logic [fb_dw-1:0] rsp_data
);

   // Decoded command channel and one bus per target
   fb_cmd_if cmd_if ();
   fb_tgt_if tgt_if [fb_nbus] ();

   fb_addr_decode u_decode (
      .clk        (clk),
      .rst        (rst),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .cmd_addr   (cmd_addr),
      .cmd_we_msk (cmd_we_msk),
      .cmd_din    (cmd_din),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .rsp_data   (rsp_data),
      .down       (cmd_if)
   );

   pb_fb_router #(
      .nbus (fb_nbus)
   ) u_router (
      .clk (clk),
      .rst (rst),
      .up  (cmd_if),
      .bus (tgt_if)
   );

   fb_sram_target #(
      .sram_words (sram_words)
   ) u_sram (
      .clk (clk),
      .rst (rst),
      .bus (tgt_if[tgt_sram])
   );

   fb_reg_target #(
      .reg_latency (reg_latency)
   ) u_regs (
      .clk (clk),
      .rst (rst),
      .bus (tgt_if[tgt_regs])
   );

endmodule

// ==== fb_testdata.hex ====
// Columns: address, write mask, write data, expected response (hex)
// Mask 0 is a read; bit 12 of the address selects the register bank
0010 f 11223344 11223344
0010 0 00000000 11223344
0014 f a5a5a5a5 a5a5a5a5
0014 3 0000beef a5a5beef
0014 0 00000000 a5a5beef
1000 0 00000000 00000000
1004 f cafef00d cafef00d
1004 c 12340000 1234f00d
1004 0 00000000 1234f00d
0020 f 01020304 01020304
1008 f 0badc0de 0badc0de
0020 0 00000000 01020304
1008 0 00000000 0badc0de
0010 8 ff000000 ff223344
100c 1 000000aa 000000aa
0010 0 00000000 ff223344

// ==== pb_fb_router.sv ====
/*
 * Frontend bus router
 * Steers the command to the selected target, allows one pending
 * target cycle at a time and returns that target's response
 */

`timescale 1ns/1ps

module pb_fb_router import fb_pkg::*; #(
   parameter int nbus = 2
) (
   input  logic      clk,
   input  logic      rst,
   fb_cmd_if.sink    up,
   fb_tgt_if.router  bus [nbus]
);

   logic [nbus-1:0]  pending;
   logic [nbus-1:0]  hs_cmd;
   logic [nbus-1:0]  hs_rsp;
   logic [nbus-1:0]  cmd_rdy;
   logic [nbus-1:0]  rsp_vld;
   logic [fb_dw-1:0] dout_m [nbus];
   logic [fb_dw-1:0] rsp_or;

   for (genvar i = 0; i < nbus; i++) begin : g_bus
      logic accept_cmd;

      assign hs_cmd[i] = bus[i].cmd_valid & bus[i].cmd_ready;
      assign hs_rsp[i] = bus[i].valid & bus[i].ready;

      // Bus is free, or already owned by this target
      assign accept_cmd = ~|pending | pending[i];

      assign bus[i].cmd_valid = up.sel[i] & accept_cmd & up.cmd_valid;
      assign cmd_rdy[i]       = up.sel[i] & accept_cmd & bus[i].cmd_ready;

      // Payload goes to every target, valid qualifies it
      assign bus[i].addr   = up.cmd.addr;
      assign bus[i].we_msk = up.cmd.we_msk;
      assign bus[i].din    = up.cmd.din;

      // Only the owner sees the response ready
      assign bus[i].ready = up.rsp_ready & pending[i];
      assign rsp_vld[i]   = pending[i] & bus[i].valid;
      assign dout_m[i]    = {fb_dw{pending[i]}} & bus[i].dout;

      // Pending bit sets on the command and clears on the response
      always_ff @(posedge clk) begin
         if (rst) begin
            pending[i] <= 1'b0;
         end else if (hs_cmd[i]) begin
            pending[i] <= 1'b1;
         end else if (hs_rsp[i]) begin
            pending[i] <= 1'b0;
         end
      end
   end

   // Non-owners are masked to zero above
   always_comb begin
      rsp_or = '0;
      for (int k = 0; k < nbus; k++) begin
         rsp_or = rsp_or | dout_m[k];
      end
   end

   assign up.cmd_ready = |cmd_rdy;
   assign up.rsp_valid = |rsp_vld;
   assign up.rsp_data  = rsp_or;

   // At most one target cycle outstanding
   a_one_pending: assert property (@(posedge clk) disable iff (rst)
      $onehot0(pending));

   // A waiting command addresses exactly one target
   a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
      up.cmd_valid |-> $onehot(up.sel));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the frontend bus testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
   --top-module tb_fb_subsystem -o tb_fb_subsystem \
   && ./obj_dir/tb_fb_subsystem > sim.log 2>&1 \
   || echo "Build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "TESTBENCH PASSED" sim.log && exit 0 || exit 1

// ==== tb_fb_subsystem.sv ====
/*
 * Frontend bus subsystem testbench
 * Replays commands from the test data file, drops rsp_ready at random
 * and checks every response word against the expected column
 */

`timescale 1ns/1ps

module tb_fb_subsystem import fb_pkg::*; ();

   localparam int n_cmds     = 16;
   localparam int wait_limit = 64;

   logic             clk;
   logic             rst;
   logic             cmd_valid;
   logic             cmd_ready;
   logic [fb_aw-1:0] cmd_addr;
   logic [fb_mw-1:0] cmd_we_msk;
   logic [fb_dw-1:0] cmd_din;
   logic             rsp_valid;
   logic             rsp_ready;
   logic [fb_dw-1:0] rsp_data;

   // Four words per command in file column order
   logic [31:0]      tdata [n_cmds*4];
   integer           seed;
   int               errors;
   int               timeouts;
   int               rsp_cnt;

   fb_subsystem_top #(
      .sram_words  (256),
      .reg_latency (3)
   ) u_fb_subsystem_top (
      .clk        (clk),
      .rst        (rst),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .cmd_addr   (cmd_addr),
      .cmd_we_msk (cmd_we_msk),
      .cmd_din    (cmd_din),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .rsp_data   (rsp_data)
   );

   // 8 ns clock
   always #4 clk = ~clk;

   // Count response transfers just ahead of each rising edge
   always @(negedge clk) begin
      #3;
      if (!rst && rsp_valid && rsp_ready) begin
         rsp_cnt++;
      end
   end

   // Present one command and hold it until cmd_ready
   task automatic send_cmd(input int i);
      int waited;
      waited = 0;
      @(negedge clk);
      cmd_valid  = 1'b1;
      cmd_addr   = tdata[4*i][fb_aw-1:0];
      cmd_we_msk = tdata[4*i+1][fb_mw-1:0];
      cmd_din    = tdata[4*i+2];
      // Inputs only move on the falling edge, so this holds until posedge
      #1;
      while (!cmd_ready && waited < wait_limit) begin
         @(negedge clk);
         #1;
         waited++;
      end
      if (!cmd_ready) begin
         $display("Timeout: command %0d was not accepted within %0d cycles", i, wait_limit);
         timeouts++;
      end
   endtask

   // Wait for the next response under random back-pressure
   task automatic collect_rsp(input int j);
      logic [fb_dw-1:0] exp;
      string            name;
      int               waited;
      logic             got;
      exp    = tdata[4*j+3];
      name   = $sformatf("rsp %0d addr %h", j, tdata[4*j][fb_aw-1:0]);
      waited = 0;
      got    = 1'b0;
      while (!got && waited < wait_limit) begin
         @(negedge clk);
         // About one cycle in four stalls
         rsp_ready = (($random(seed) & 32'sd3) != 32'sd0);
         #1;
         if (rsp_valid && rsp_ready) begin
            got = 1'b1;
            assert (rsp_data === exp) else begin
               $display("[ERROR] %s expected %h actual %h", name, exp, rsp_data);
               errors++;
            end
         end
         waited++;
      end
      if (!got) begin
         $display("Timeout: response %0d did not arrive within %0d cycles", j, wait_limit);
         timeouts++;
      end
   endtask

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      cmd_valid  = 1'b0;
      cmd_addr   = '0;
      cmd_we_msk = '0;
      cmd_din    = '0;
      rsp_ready  = 1'b0;
      seed       = 32'h15e9;
      errors     = 0;
      timeouts   = 0;
      rsp_cnt    = 0;
      $readmemh("fb_testdata.hex", tdata);

      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      #1;
      // Idle state right after reset
      assert (rsp_valid === 1'b0) else begin
         $display("[ERROR] reset rsp_valid expected 0 actual %b", rsp_valid);
         errors++;
      end
      assert (cmd_ready === 1'b1) else begin
         $display("[ERROR] reset cmd_ready expected 1 actual %b", cmd_ready);
         errors++;
      end

      // Command and response sides run side by side
      fork
         begin
            for (int i = 0; i < n_cmds && timeouts == 0; i++) begin
               send_cmd(i);
            end
            @(negedge clk);
            cmd_valid = 1'b0;
         end
         begin
            for (int j = 0; j < n_cmds && timeouts == 0; j++) begin
               collect_rsp(j);
            end
         end
      join

      // Bus must stay quiet once every response is in
      for (int k = 0; k < 16; k++) begin
         @(negedge clk);
         rsp_ready = 1'b1;
         #1;
         assert (rsp_valid === 1'b0) else begin
            $display("Extra response seen after all commands completed, data %h", rsp_data);
            errors++;
         end
      end
      assert (rsp_cnt == n_cmds) else begin
         $display("[ERROR] response count expected %0d actual %0d", n_cmds, rsp_cnt);
         errors++;
      end

      $display("Errors %0d, timeouts %0d, responses %0d of %0d",
               errors, timeouts, rsp_cnt, n_cmds);
      if (errors == 0 && timeouts == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
fb_pkg.sv
fb_if.sv
fb_addr_decode.sv
pb_fb_router.sv
fb_sram_target.sv
fb_reg_target.sv
fb_subsystem_top.sv
tb_fb_subsystem.sv
